// File: verilog/soc_pkg.sv
package soc_pkg;

    // cluster and memory geometry
    localparam int N_CLUSTERS   = 4;
    localparam int ADDR_W       = 8;                      // word address, not byte address
    localparam int DATA_W       = 32;
    localparam int MEM_WORDS    = 1 << ADDR_W;
    localparam int REGION_WORDS = 64;                     // one region per cluster
    localparam int PROG_WORDS   = 32;                     // program sits in the low half of a region

    // masters on the L2 interconnect are the cores followed by the host port
    localparam int N_MASTERS    = N_CLUSTERS + 1;
    localparam int EXT_MASTER   = 4;
    localparam int MST_W        = $clog2(N_MASTERS);

    // request from any master towards the L2
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              we;
    } mem_req_t;

    // a write gets a response too, it acts as the acknowledgement
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

// File: verilog/core_pkg.sv
package core_pkg;

    // a zero word decodes as halt so that an empty program stops at once
    typedef enum logic [3:0] {
        OP_HALT  = 4'h0,
        OP_LOAD  = 4'h1,
        OP_ADD   = 4'h2,
        OP_ADDI  = 4'h3,
        OP_XOR   = 4'h4,
        OP_STORE = 4'h5
    } opcode_e;

    typedef struct packed {
        opcode_e     op;      // bits 31:28
        logic [3:0]  rsvd;    // bits 27:24, ignored by the core
        logic [7:0]  addr;    // absolute word address
        logic [15:0] imm;     // zero extended by addi
    } instr_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        FETCH_WAIT,
        EXEC,
        MEM_WAIT,
        DONE
    } core_state_e;

endpackage

// File: verilog/l2_mem.sv
`timescale 1ns/1ps

module l2_mem
    import soc_pkg::*;
(
    input  logic     clk,
    input  logic     req_valid,
    input  mem_req_t req,
    output mem_rsp_t rsp
);

    logic [DATA_W-1:0] mem [MEM_WORDS];

    // a write returns the old word, the requester only needs the ack
    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            if (req.we)
                mem[req.addr] <= req.wdata;
            rsp.rdata <= mem[req.addr];
        end
    end

endmodule

// File: verilog/mem_interconnect.sv
`timescale 1ns/1ps

module mem_interconnect
    import soc_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [N_MASTERS-1:0] req_valid,
    input  mem_req_t             req [N_MASTERS],
    input  mem_rsp_t             mem_rsp,
    output logic [N_MASTERS-1:0] req_ready,
    output logic [N_MASTERS-1:0] rsp_valid,
    output mem_rsp_t             rsp,
    output logic                 mem_req_valid,
    output mem_req_t             mem_req
);

    logic [MST_W-1:0] last_grant;
    logic [MST_W-1:0] grant_idx;
    logic             grant_any;
    logic [MST_W-1:0] rsp_idx;
    logic             rsp_pending;

    // search starts one past the previous winner
    always_comb
    begin
        int cand;
        grant_any = 1'b0;
        grant_idx = last_grant;
        for (int k = 1; k <= N_MASTERS; k++)
        begin
            cand = (int'(last_grant) + k) % N_MASTERS;
            if (!grant_any && req_valid[cand])
            begin
                grant_any = 1'b1;
                grant_idx = MST_W'(cand);
            end
        end
    end

    always_comb
    begin
        req_ready = '0;
        if (grant_any)
            req_ready[grant_idx] = 1'b1;
    end

    assign mem_req_valid = grant_any;
    assign mem_req       = req[grant_idx];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            last_grant  <= MST_W'(N_MASTERS - 1);    // master 0 wins first after reset
            rsp_pending <= 1'b0;
            rsp_idx     <= '0;
        end
        else
        begin
            rsp_pending <= grant_any;
            if (grant_any)
            begin
                last_grant <= grant_idx;
                rsp_idx    <= grant_idx;
            end
        end
    end

    // the memory answers one cycle after the grant, only the owner sees it as valid
    always_comb
    begin
        rsp_valid = '0;
        if (rsp_pending)
            rsp_valid[rsp_idx] = 1'b1;
    end

    assign rsp = mem_rsp;

endmodule

// File: verilog/cluster_core.sv
`timescale 1ns/1ps

module cluster_core
    import soc_pkg::*, core_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       fetch_en,
    input  logic [1:0] core_id,
    input  logic       req_ready,
    input  logic       rsp_valid,
    input  mem_rsp_t   rsp,
    output logic       req_valid,
    output mem_req_t   req,
    output logic       eoc
);

    localparam int PC_W = $clog2(PROG_WORDS);

    core_state_e       state;
    logic [PC_W-1:0]   pc;
    logic [DATA_W-1:0] acc;
    instr_t            ir;
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] fetch_addr;
    logic              mem_op;

    assign base       = ADDR_W'(core_id * REGION_WORDS);
    assign fetch_addr = base + ADDR_W'(pc);   // pc wraps inside the program half of the region
    assign mem_op     = ir.op inside {OP_LOAD, OP_ADD, OP_XOR, OP_STORE};
    assign eoc        = (state == DONE);

    // the request only depends on registered state, so it holds while a grant is withheld
    always_comb
    begin
        req_valid = 1'b0;
        req.addr  = fetch_addr;
        req.wdata = acc;
        req.we    = 1'b0;
        case (state)
            FETCH:
                req_valid = 1'b1;
            EXEC:
            begin
                req_valid = mem_op;
                req.addr  = ir.addr;
                req.we    = (ir.op == OP_STORE);
            end
            default:
                req_valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
            pc    <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (fetch_en)
                    begin
                        pc    <= '0;
                        state <= FETCH;
                    end
                FETCH:
                    if (req_ready)
                        state <= FETCH_WAIT;
                FETCH_WAIT:
                    if (rsp_valid)
                        state <= EXEC;
                EXEC:
                    if (mem_op)
                    begin
                        if (req_ready)
                            state <= MEM_WAIT;
                    end
                    else if (ir.op == OP_ADDI)
                    begin
                        pc    <= pc + 1'b1;
                        state <= FETCH;
                    end
                    else
                        state <= DONE;    // halt and every undefined opcode
                MEM_WAIT:
                    if (rsp_valid)
                    begin
                        pc    <= pc + 1'b1;
                        state <= FETCH;
                    end
                DONE:
                    if (!fetch_en)
                        state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        case (state)
            IDLE:
                if (fetch_en)
                    acc <= '0;    // every run starts from a clean accumulator
            FETCH_WAIT:
                if (rsp_valid)
                    ir <= instr_t'(rsp.rdata);
            EXEC:
                if (ir.op == OP_ADDI)
                    acc <= acc + DATA_W'(ir.imm);
            MEM_WAIT:
                if (rsp_valid)
                begin
                    case (ir.op)
                        OP_LOAD: acc <= rsp.rdata;
                        OP_ADD:  acc <= acc + rsp.rdata;
                        OP_XOR:  acc <= acc ^ rsp.rdata;
                        default: acc <= acc;    // store only waits for its ack
                    endcase
                end
            default:
                acc <= acc;
        endcase
    end

endmodule

// File: verilog/soc_top.sv
`timescale 1ns/1ps

module soc_top
    import soc_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [N_CLUSTERS-1:0] fetch_en,
    input  logic                  ext_req_valid,
    input  mem_req_t              ext_req,
    output logic                  ext_req_ready,
    output logic                  ext_rsp_valid,
    output mem_rsp_t              ext_rsp,
    output logic [N_CLUSTERS-1:0] eoc
);

    logic [N_MASTERS-1:0] m_req_valid;
    logic [N_MASTERS-1:0] m_req_ready;
    logic [N_MASTERS-1:0] m_rsp_valid;
    mem_req_t             m_req [N_MASTERS];
    mem_rsp_t             bus_rsp;
    logic                 l2_req_valid;
    mem_req_t             l2_req;
    mem_rsp_t             l2_rsp;

    for (genvar g = 0; g < N_CLUSTERS; g++)
    begin : g_cluster
        cluster_core core_i
        (
            .clk       ( clk            ),
            .rst       ( rst            ),
            .fetch_en  ( fetch_en[g]    ),
            .core_id   ( 2'(g)          ),
            .req_ready ( m_req_ready[g] ),
            .rsp_valid ( m_rsp_valid[g] ),
            .rsp       ( bus_rsp        ),
            .req_valid ( m_req_valid[g] ),
            .req       ( m_req[g]       ),
            .eoc       ( eoc[g]         )
        );
    end

    // host port is the last master on the interconnect
    assign m_req_valid[EXT_MASTER] = ext_req_valid;
    assign m_req[EXT_MASTER]       = ext_req;
    assign ext_req_ready           = m_req_ready[EXT_MASTER];
    assign ext_rsp_valid           = m_rsp_valid[EXT_MASTER];
    assign ext_rsp                 = bus_rsp;

    mem_interconnect xbar_i
    (
        .clk           ( clk          ),
        .rst           ( rst          ),
        .req_valid     ( m_req_valid  ),
        .req           ( m_req        ),
        .mem_rsp       ( l2_rsp       ),
        .req_ready     ( m_req_ready  ),
        .rsp_valid     ( m_rsp_valid  ),
        .rsp           ( bus_rsp      ),
        .mem_req_valid ( l2_req_valid ),
        .mem_req       ( l2_req       )
    );

    l2_mem l2_i
    (
        .clk       ( clk          ),
        .req_valid ( l2_req_valid ),
        .req       ( l2_req       ),
        .rsp       ( l2_rsp       )
    );

endmodule

// File: bench/soc_props.sv
`timescale 1ns/1ps

module soc_props
    import soc_pkg::*;
(
    input logic                 clk,
    input logic                 rst,
    input logic [N_MASTERS-1:0] req_valid,
    input mem_req_t             req [N_MASTERS],
    input logic [N_MASTERS-1:0] req_ready,
    input logic [N_MASTERS-1:0] rsp_valid
);

    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        $onehot0(req_ready) && (req_ready & ~req_valid) == '0)
        else $error("grant %b is not one requesting master, requests %b", req_ready, req_valid);

    // the L2 answers on the next cycle and only the granted master sees it
    a_rsp_route: assert property (@(posedge clk) disable iff (rst)
        1'b1 |=> rsp_valid == $past(req_ready))
        else $error("response valid %b does not follow the previous grant", rsp_valid);

    for (genvar m = 0; m < N_MASTERS; m++)
    begin : g_stable
        int wait_cnt;    // cycles this master has been passed over

        always_ff @(posedge clk)
        begin
            if (rst || !req_valid[m] || req_ready[m])
                wait_cnt <= 0;
            else
                wait_cnt <= wait_cnt + 1;
        end

        a_hold: assert property (@(posedge clk) disable iff (rst)
            req_valid[m] && !req_ready[m] |=> req_valid[m] && req[m] == $past(req[m]))
            else $error("master %0d dropped or changed a waiting request", m);

        // round robin lets each of the other masters go at most once first
        a_fair: assert property (@(posedge clk) disable iff (rst)
            wait_cnt < N_MASTERS)
            else $error("master %0d starved for %0d cycles", m, wait_cnt);
    end

endmodule

bind mem_interconnect soc_props props_i
(
    .clk       ( clk       ),
    .rst       ( rst       ),
    .req_valid ( req_valid ),
    .req       ( req       ),
    .req_ready ( req_ready ),
    .rsp_valid ( rsp_valid )
);

// File: bench/tb_multicluster.sv
`timescale 1ns/1ps

module tb_multicluster
    import soc_pkg::*, core_pkg::*;
();

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 16;
    localparam int N_TESTS         = 6;
    localparam int HOST_BUDGET     = 1024 * 4;    // host loads and read-backs on top of the runs
    localparam int WATCHDOG_CYCLES =
        N_TESTS * PROG_WORDS * 2 * N_MASTERS * 2 + RESET_CYCLES + HOST_BUDGET;
    localparam int HOT_ADDR        = 2 * REGION_WORDS + 63;
    localparam int STORE_SPAN      = 16;          // stores stay in the low data words

    typedef logic [DATA_W-1:0] mem_img_t [MEM_WORDS];

    logic                  clk = 1'b0;
    logic                  rst;
    logic [N_CLUSTERS-1:0] fetch_en;
    logic                  ext_req_valid;
    mem_req_t              ext_req;
    logic                  ext_req_ready;
    logic                  ext_rsp_valid;
    mem_rsp_t              ext_rsp;
    logic [N_CLUSTERS-1:0] eoc;

    mem_img_t          img;
    integer            seed;
    int                n_checks = 0;
    int                n_errors = 0;
    string             name_q [$];
    logic [DATA_W-1:0] exp_q [$];
    logic [DATA_W-1:0] act_q [$];

    soc_top DUT
    (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .fetch_en      ( fetch_en      ),
        .ext_req_valid ( ext_req_valid ),
        .ext_req       ( ext_req       ),
        .ext_req_ready ( ext_req_ready ),
        .ext_rsp_valid ( ext_rsp_valid ),
        .ext_rsp       ( ext_rsp       ),
        .eoc           ( eoc           )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [DATA_W-1:0] expected,
                         input logic [DATA_W-1:0] actual);
        n_checks++;
        if (actual !== expected)
        begin
            n_errors++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic post(input string name, input logic [DATA_W-1:0] expected,
                        input logic [DATA_W-1:0] actual);
        name_q.push_back(name);
        exp_q.push_back(expected);
        act_q.push_back(actual);
    endtask

    // the request holds until the accepting edge, then the response follows one cycle later
    task automatic host_transfer(input int addr, input logic [DATA_W-1:0] wdata,
                                 input logic we, output logic [DATA_W-1:0] rdata);
        @(posedge clk);
        ext_req_valid <= 1'b1;
        ext_req       <= '{addr: ADDR_W'(addr), wdata: wdata, we: we};
        @(negedge clk);
        while (!ext_req_ready)
            @(negedge clk);
        @(posedge clk);
        ext_req_valid <= 1'b0;
        @(negedge clk);
        while (!ext_rsp_valid)
            @(negedge clk);
        rdata = ext_rsp.rdata;
    endtask

    task automatic ext_write(input int addr, input logic [DATA_W-1:0] wdata);
        logic [DATA_W-1:0] ack;
        host_transfer(addr, wdata, 1'b1, ack);
    endtask

    task automatic ext_read(input int addr, output logic [DATA_W-1:0] rdata);
        host_transfer(addr, '0, 1'b0, rdata);
    endtask

    function automatic logic [DATA_W-1:0] encode(input logic [3:0] op, input int addr,
                                                 input logic [15:0] imm);
        return {op, 4'h0, 8'(addr), imm};
    endfunction

    // clusters run one after another here, which is exact because regions are disjoint
    function automatic void model_run(input mem_img_t start, input logic [N_CLUSTERS-1:0] en,
                                      output mem_img_t result);
        logic [DATA_W-1:0] word;
        logic [DATA_W-1:0] acc;
        logic [7:0]        addr;
        int                pc;
        int                steps;
        bit                running;
        result = start;
        for (int c = 0; c < N_CLUSTERS; c++)
        begin
            acc     = '0;
            pc      = 0;
            steps   = 0;
            running = en[c];
            while (running && steps < 4 * PROG_WORDS)
            begin
                word = result[c * REGION_WORDS + pc];
                addr = word[23:16];
                pc   = (pc + 1) % PROG_WORDS;
                steps++;
                case (word[31:28])
                    OP_LOAD:  acc = result[addr];
                    OP_ADD:   acc = acc + result[addr];
                    OP_ADDI:  acc = acc + {16'h0, word[15:0]};
                    OP_XOR:   acc = acc ^ result[addr];
                    OP_STORE: result[addr] = acc;
                    default:  running = 1'b0;    // halt and any unknown code
                endcase
            end
        end
    endfunction

    task automatic make_program(input int r);
        logic [3:0] ops [5] = '{OP_LOAD, OP_ADD, OP_ADDI, OP_XOR, OP_STORE};
        int         base;
        int         len;
        int         pick;
        int         addr;
        logic [15:0] imm;
        base      = r * REGION_WORDS;
        len       = 8 + ($unsigned($random(seed)) % 20);
        img[base] = encode(OP_LOAD, base + PROG_WORDS + ($unsigned($random(seed)) % 32), 16'h0);
        for (int k = 1; k < PROG_WORDS; k++)
        begin
            pick = $unsigned($random(seed)) % 5;
            addr = $unsigned($random(seed)) % ((pick == 4) ? STORE_SPAN : PROG_WORDS);
            imm  = 16'($random(seed));
            if (k >= len)
                img[base + k] = encode(OP_HALT, 0, 16'h0);
            else
                img[base + k] = encode(ops[pick], base + PROG_WORDS + addr, imm);
        end
    endtask

    task automatic fill_data(input int r);
        for (int k = PROG_WORDS; k < REGION_WORDS; k++)
            img[r * REGION_WORDS + k] = $random(seed);
    endtask

    task automatic load_words(input int r, input int first, input int last);
        for (int k = first; k <= last; k++)
            ext_write(r * REGION_WORDS + k, img[r * REGION_WORDS + k]);
    endtask

    task automatic read_back(input string name, input int r);
        logic [DATA_W-1:0] v;
        for (int k = PROG_WORDS; k < REGION_WORDS; k++)
        begin
            ext_read(r * REGION_WORDS + k, v);
            post(name, img[r * REGION_WORDS + k], v);
        end
    endtask

    task automatic start_clusters(input logic [N_CLUSTERS-1:0] mask);
        @(posedge clk);
        fetch_en <= mask;
    endtask

    task automatic wait_eoc(input logic [N_CLUSTERS-1:0] mask);
        @(negedge clk);
        while ((eoc & mask) != mask)
            @(negedge clk);
    endtask

    // eoc holds through the edge that drops fetch_en and is gone one edge later
    task automatic stop_clusters(input string name, input logic [N_CLUSTERS-1:0] done);
        @(posedge clk);
        fetch_en <= '0;
        @(negedge clk);
        post({name, "_held"}, done, eoc);
        @(negedge clk);
        post(name, '0, eoc);
    endtask

    always @(negedge clk)
    begin
        while (exp_q.size() > 0)
            check(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
        $display("%0d checks, %0d errors", n_checks, n_errors);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        logic [DATA_W-1:0]     v;
        int                    addrs [16];
        logic [N_CLUSTERS-1:0] other_eoc;
        mem_img_t              expected;
        int                    b;
        seed          = 71272;
        rst           <= 1'b1;
        fetch_en      <= '0;
        ext_req_valid <= 1'b0;
        ext_req       <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 16; i++)
        begin
            addrs[i] = ($unsigned($random(seed)) % N_CLUSTERS) * REGION_WORDS + PROG_WORDS;
            addrs[i] += $unsigned($random(seed)) % PROG_WORDS;
            img[addrs[i]] = $random(seed);
            ext_write(addrs[i], img[addrs[i]]);
        end
        for (int i = 0; i < 16; i++)
        begin
            ext_read(addrs[i], v);
            post("host_access", img[addrs[i]], v);
        end

        make_program(0);
        fill_data(0);
        load_words(0, 0, REGION_WORDS - 1);
        start_clusters(4'b0001);
        other_eoc = '0;
        @(negedge clk);
        while (!eoc[0])
        begin
            other_eoc |= eoc & 4'b1110;
            @(negedge clk);
        end
        post("single_other_eoc", '0, other_eoc | (eoc & 4'b1110));
        model_run(img, 4'b0001, expected);
        img = expected;
        read_back("single_cluster", 0);
        stop_clusters("single_stop", 4'b0001);

        for (int r = 0; r < N_CLUSTERS; r++)
        begin
            make_program(r);
            fill_data(r);
            load_words(r, 0, REGION_WORDS - 1);
        end
        start_clusters('1);
        do
        begin
            ext_read(HOT_ADDR, v);    // competes with all four cores for grants
            post("contention", img[HOT_ADDR], v);
        end
        while (eoc != '1);
        model_run(img, '1, expected);
        img = expected;
        for (int r = 0; r < N_CLUSTERS; r++)
            read_back("all_clusters", r);

        stop_clusters("restart_eoc_low", '1);
        for (int r = 0; r < N_CLUSTERS; r++)
        begin
            fill_data(r);
            load_words(r, PROG_WORDS, REGION_WORDS - 1);
        end
        start_clusters('1);
        wait_eoc('1);
        model_run(img, '1, expected);
        img = expected;
        for (int r = 0; r < N_CLUSTERS; r++)
            read_back("restart", r);
        stop_clusters("restart_stop", '1);

        // the store after the unknown code must never reach memory
        b          = REGION_WORDS;
        img[b]     = encode(OP_LOAD, b + 40, 16'h0);
        img[b + 1] = encode(OP_ADDI, 0, 16'h1234);
        img[b + 2] = encode(OP_STORE, b + 33, 16'h0);
        img[b + 3] = encode(4'hb, 0, 16'h0);
        img[b + 4] = encode(OP_ADDI, 0, 16'h0001);
        img[b + 5] = encode(OP_STORE, b + 34, 16'h0);
        for (int k = 6; k < PROG_WORDS; k++)
            img[b + k] = encode(OP_HALT, 0, 16'h0);
        fill_data(1);
        load_words(1, 0, REGION_WORDS - 1);
        start_clusters(4'b0010);
        wait_eoc(4'b0010);
        post("undefined_eoc", 4'b0010, eoc);
        model_run(img, 4'b0010, expected);
        img = expected;
        read_back("undefined_opcode", 1);
        stop_clusters("undefined_stop", 4'b0010);

        while (exp_q.size() != 0)
            @(posedge clk);
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: sim.f
verilog/soc_pkg.sv
verilog/core_pkg.sv
verilog/l2_mem.sv
verilog/mem_interconnect.sv
verilog/cluster_core.sv
verilog/soc_top.sv
bench/soc_props.sv
bench/tb_multicluster.sv

// File: Bender.yml
package:
  name: multicluster_soc

sources:
  - verilog/soc_pkg.sv
  - verilog/core_pkg.sv
  - verilog/l2_mem.sv
  - verilog/mem_interconnect.sv
  - verilog/cluster_core.sv
  - verilog/soc_top.sv
  - target: test
    files:
      - bench/soc_props.sv
      - bench/tb_multicluster.sv
